//--- dscrptrFetch_defs.svh
`ifndef DSCRPTR_FETCH_DEFS_SVH
`define DSCRPTR_FETCH_DEFS_SVH

//////////////////////////////
// Bus widths
//////////////////////////////

// Memory address width
`define ADDR_WIDTH 32

// Internal descriptor slot number
`define SLOT_WIDTH 2

//////////////////////////////
// Queue and credits
//////////////////////////////

// Fetched descriptor queue entries, also the credit count after reset
`define DSCRPTR_QUEUE_DEPTH 4

// Must hold the full queue depth, not just its top index
`define CREDIT_WIDTH ($clog2(`DSCRPTR_QUEUE_DEPTH + 1))

//////////////////////////////
// Config word access
//////////////////////////////

// Ready check reads from the byte lane holding the data-valid bit
`define CONFIG_BYTE_OFFSET 1

`endif

//--- dscrptrPkg.sv
`default_nettype none

`include "dscrptrFetch_defs.svh"

package dscrptrPkg;

    //////////////////////////////
    // Descriptor config word
    //////////////////////////////

    // Field layout of the config word
    typedef struct packed {
        logic [17:0] reserved;
        logic        dataValid;
        logic [12:0] ctrl;
    } configFields_t;

    // Same word seen as fields or as memory byte lanes
    typedef union packed {
        configFields_t   fields;
        logic [3:0][7:0] lanes;
    } configWord_u;

    // Complete 128-bit external descriptor
    typedef struct packed {
        configWord_u             configWord;
        logic [`ADDR_WIDTH-1:0]  srcAddr;
        logic [`ADDR_WIDTH-1:0]  dstAddr;
        logic [`ADDR_WIDTH-1:0]  nextAddr;
    } dscrptr_t;

    //////////////////////////////
    // Command and memory ports
    //////////////////////////////

    typedef struct packed {
        logic                    isCheck;
        logic [`ADDR_WIDTH-1:0]  addr;
        logic [`SLOT_WIDTH-1:0]  slot;
    } fetchCmd_t;

    typedef struct packed {
        logic                    isCheck;
        logic [`ADDR_WIDTH-1:0]  addr;
    } rdReq_t;

    // Read response with both data-valid flags from the bus
    typedef struct packed {
        dscrptr_t                data;
        logic [1:0]              dataValid;
        logic                    dscrptrValid;
    } rdResp_t;

    // One queue entry, as handed to the transfer controller
    typedef struct packed {
        dscrptr_t                dscrptr;
        logic [`ADDR_WIDTH-1:0]  addr;
        logic [`SLOT_WIDTH-1:0]  slot;
        logic                    dscrptrValid;
    } dscrptrEntry_t;

endpackage

`default_nettype wire

//--- fetchSequencer.sv
`default_nettype none

`include "dscrptrFetch_defs.svh"

module fetchSequencer (
    input  logic                       clock,
    input  logic                       resetn,
    input  logic                       cmdValid,
    input  dscrptrPkg::fetchCmd_t      cmd,
    output logic                       cmdReady,
    output logic                       rdReqValid,
    output dscrptrPkg::rdReq_t         rdReq,
    input  logic                       rdRespValid,
    input  dscrptrPkg::rdResp_t        rdResp,
    input  logic                       creditReturn,
    output logic                       qWrite,
    output dscrptrPkg::dscrptrEntry_t  qEntry,
    output logic                       rdyValid,
    output logic                       rdy
);
    import dscrptrPkg::*;

    typedef enum logic [1:0] {IDLE, FETCH_WAIT, CHECK_WAIT} state_e;

    localparam logic [`CREDIT_WIDTH-1:0] CREDIT_INIT = `DSCRPTR_QUEUE_DEPTH;

    state_e                    state;
    state_e                    nextState;
    logic [`CREDIT_WIDTH-1:0]  creditCount;
    rdReq_t                    reqReg;
    logic [`SLOT_WIDTH-1:0]    slotReg;
    logic                      cmdAccept;
    logic                      checkDone;
    logic                      dvAnd;
    configWord_u               cfgFold;

    //////////////////////////////
    // Command handshake
    //////////////////////////////

    // A ready check spends no queue slot, so it needs no credit
    assign cmdReady  = (state == IDLE) && (cmd.isCheck || (creditCount != '0));
    assign cmdAccept = cmdValid && cmdReady;

    always_comb
    begin
        nextState = state;
        unique case (state)
            IDLE:
                if (cmdAccept)
                    nextState = cmd.isCheck ? CHECK_WAIT : FETCH_WAIT;
            FETCH_WAIT,
            CHECK_WAIT:
                if (rdRespValid)
                    nextState = IDLE;
            default:
                nextState = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
            state <= IDLE;
        else
            state <= nextState;
    end

    // Request latched and held until the response strobe
    always_ff @(posedge clock)
    begin
        if (cmdAccept)
        begin
            reqReg.isCheck <= cmd.isCheck;
            reqReg.addr    <= cmd.isCheck ? cmd.addr + `ADDR_WIDTH'(`CONFIG_BYTE_OFFSET)
                                          : cmd.addr;
            slotReg        <= cmd.slot;
        end
    end

    assign rdReqValid = (state != IDLE);
    assign rdReq      = reqReg;

    //////////////////////////////
    // Response handling
    //////////////////////////////

    assign dvAnd     = &rdResp.dataValid;
    assign qWrite    = (state == FETCH_WAIT) && rdRespValid;
    assign checkDone = (state == CHECK_WAIT) && rdRespValid;

    // Fold both bus data-valid flags into the config word
    always_comb
    begin
        cfgFold                  = rdResp.data.configWord;
        cfgFold.fields.dataValid = dvAnd;
    end

    always_comb
    begin
        qEntry.dscrptr            = rdResp.data;
        qEntry.dscrptr.configWord = cfgFold;
        qEntry.addr               = reqReg.addr;
        qEntry.slot               = slotReg;
        qEntry.dscrptrValid       = rdResp.dscrptrValid;
    end

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            rdyValid <= 1'b0;
            rdy      <= 1'b0;
        end
        else
        begin
            rdyValid <= checkDone;
            rdy      <= checkDone && dvAnd;
        end
    end

    // Credits spent on each queue write and returned on each pop
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
            creditCount <= CREDIT_INIT;
        else
        begin
            unique case ({qWrite, creditReturn})
                2'b10:   creditCount <= creditCount - 1'b1;
                2'b01:   creditCount <= creditCount + 1'b1;
                default: creditCount <= creditCount;
            endcase
        end
    end

    //////////////////////////////
    // Assertions
    //////////////////////////////

    // Queue must not return more credits than it has entries
    assert property (@(posedge clock) disable iff (!resetn)
        creditCount <= CREDIT_INIT);

    assert property (@(posedge clock) disable iff (!resetn)
        rdReqValid && !rdRespValid |=> rdReqValid && $stable(rdReq));

endmodule

`default_nettype wire

//--- dscrptrQueue.sv
`default_nettype none

`include "dscrptrFetch_defs.svh"

module dscrptrQueue (
    input  logic                       clock,
    input  logic                       resetn,
    input  logic                       qWrite,
    input  dscrptrPkg::dscrptrEntry_t  qEntry,
    input  logic                       qPop,
    output dscrptrPkg::dscrptrEntry_t  qHead,
    output logic                       qNotEmpty,
    output logic                       creditReturn
);
    import dscrptrPkg::*;

    localparam int PTR_WIDTH = (`DSCRPTR_QUEUE_DEPTH > 1) ? $clog2(`DSCRPTR_QUEUE_DEPTH) : 1;
    localparam logic [PTR_WIDTH-1:0]     LAST_PTR   = PTR_WIDTH'(`DSCRPTR_QUEUE_DEPTH - 1);
    localparam logic [`CREDIT_WIDTH-1:0] FULL_COUNT = `DSCRPTR_QUEUE_DEPTH;

    dscrptrEntry_t             entries [`DSCRPTR_QUEUE_DEPTH];
    logic [PTR_WIDTH-1:0]      wrPtr;
    logic [PTR_WIDTH-1:0]      rdPtr;
    logic [`CREDIT_WIDTH-1:0]  count;

    // Wraps at the depth, which need not be a power of two
    function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
        nextPtr = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clock)
    begin
        if (qWrite)
            entries[wrPtr] <= qEntry;
    end

    assign qHead     = entries[rdPtr];
    assign qNotEmpty = (count != '0);

    //////////////////////////////
    // Pointers and count
    //////////////////////////////

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            count        <= '0;
            creditReturn <= 1'b0;
        end
        else
        begin
            if (qWrite)
                wrPtr <= nextPtr(wrPtr);
            if (qPop)
                rdPtr <= nextPtr(rdPtr);
            unique case ({qWrite, qPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back to the sequencer per pop
            creditReturn <= qPop;
        end
    end

    // Credits in the sequencer keep the queue from overflowing
    assert property (@(posedge clock) disable iff (!resetn)
        qWrite |-> count != FULL_COUNT);

    assert property (@(posedge clock) disable iff (!resetn)
        qPop |-> qNotEmpty);

endmodule

`default_nettype wire

//--- dscrptrLoader.sv
`default_nettype none

module dscrptrLoader (
    input  logic                       clock,
    input  logic                       resetn,
    input  logic                       qNotEmpty,
    input  dscrptrPkg::dscrptrEntry_t  qHead,
    output logic                       qPop,
    output logic                       load,
    output dscrptrPkg::dscrptrEntry_t  loadEntry,
    input  logic                       loadAck,
    output logic                       fetchDone
);

    logic ackTaken;

    //////////////////////////////
    // Pop and hold
    //////////////////////////////

    // Only pop into an empty holding register
    assign qPop     = qNotEmpty && !load;
    assign ackTaken = load && loadAck;

    always_ff @(posedge clock)
    begin
        if (qPop)
            loadEntry <= qHead;
    end

    //////////////////////////////
    // Load handshake
    //////////////////////////////

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            load      <= 1'b0;
            fetchDone <= 1'b0;
        end
        else
        begin
            if (qPop)
                load <= 1'b1;
            else if (ackTaken)
                load <= 1'b0;
            // Done strobe one cycle after the acknowledge
            fetchDone <= ackTaken;
        end
    end

    // Controller sees a steady descriptor until it acknowledges
    assert property (@(posedge clock) disable iff (!resetn)
        load && !loadAck |=> load && $stable(loadEntry));

endmodule

`default_nettype wire

//--- dscrptrFetchTop.sv
`default_nettype none

module dscrptrFetchTop (
    input  logic                       clock,
    input  logic                       resetn,
    // Command port
    input  logic                       cmdValid,
    input  dscrptrPkg::fetchCmd_t      cmd,
    output logic                       cmdReady,
    // Memory port
    output logic                       rdReqValid,
    output dscrptrPkg::rdReq_t         rdReq,
    input  logic                       rdRespValid,
    input  dscrptrPkg::rdResp_t        rdResp,
    // Ready check result
    output logic                       rdyValid,
    output logic                       rdy,
    // Transfer controller load port
    output logic                       load,
    output dscrptrPkg::dscrptrEntry_t  loadEntry,
    input  logic                       loadAck,
    output logic                       fetchDone
);
    import dscrptrPkg::*;

    //////////////////////////////
    // Internal links
    //////////////////////////////

    logic           qWrite;
    dscrptrEntry_t  qEntry;
    logic           creditReturn;
    logic           qPop;
    dscrptrEntry_t  qHead;
    logic           qNotEmpty;

    fetchSequencer uSequencer (
        .clock        (clock),
        .resetn       (resetn),
        .cmdValid     (cmdValid),
        .cmd          (cmd),
        .cmdReady     (cmdReady),
        .rdReqValid   (rdReqValid),
        .rdReq        (rdReq),
        .rdRespValid  (rdRespValid),
        .rdResp       (rdResp),
        .creditReturn (creditReturn),
        .qWrite       (qWrite),
        .qEntry       (qEntry),
        .rdyValid     (rdyValid),
        .rdy          (rdy)
    );

    dscrptrQueue uQueue (
        .clock        (clock),
        .resetn       (resetn),
        .qWrite       (qWrite),
        .qEntry       (qEntry),
        .qPop         (qPop),
        .qHead        (qHead),
        .qNotEmpty    (qNotEmpty),
        .creditReturn (creditReturn)
    );

    dscrptrLoader uLoader (
        .clock        (clock),
        .resetn       (resetn),
        .qNotEmpty    (qNotEmpty),
        .qHead        (qHead),
        .qPop         (qPop),
        .load         (load),
        .loadEntry    (loadEntry),
        .loadAck      (loadAck),
        .fetchDone    (fetchDone)
    );

endmodule

`default_nettype wire

//--- dscrptrFetchTb.sv
`default_nettype none

`include "dscrptrFetch_defs.svh"

module dscrptrFetchTb;
    import dscrptrPkg::*;

    localparam int DRIVE_DLY = 2;
    localparam int TIMEOUT   = 300;

    // One stimulus row with expDv as the expected AND of both data-valid bits
    typedef struct {
        string                   name;
        logic                    isCheck;
        logic [`ADDR_WIDTH-1:0]  addr;
        logic [`SLOT_WIDTH-1:0]  slot;
        logic [31:0]             cfg;
        logic [1:0]              dataValid;
        logic                    dscrptrValid;
        logic                    expDv;
    } stimRow_t;

    logic           clock = 1'b0;
    logic           resetn;
    logic           cmdValid;
    fetchCmd_t      cmd;
    logic           cmdReady;
    logic           rdReqValid;
    rdReq_t         rdReq;
    logic           rdRespValid;
    rdResp_t        rdResp;
    logic           rdyValid;
    logic           rdy;
    logic           load;
    dscrptrEntry_t  loadEntry;
    logic           loadAck;
    logic           fetchDone;

    stimRow_t       stimTable [$];
    dscrptrEntry_t  expQ [$];
    int             acksAllowed;
    int             fetchCount;
    int             ackCount;

    dscrptrFetchTop dut (
        .clock       (clock),
        .resetn      (resetn),
        .cmdValid    (cmdValid),
        .cmd         (cmd),
        .cmdReady    (cmdReady),
        .rdReqValid  (rdReqValid),
        .rdReq       (rdReq),
        .rdRespValid (rdRespValid),
        .rdResp      (rdResp),
        .rdyValid    (rdyValid),
        .rdy         (rdy),
        .load        (load),
        .loadEntry   (loadEntry),
        .loadAck     (loadAck),
        .fetchDone   (fetchDone)
    );

    always #10 clock = ~clock;

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic failRun();
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            failRun();
        end
    endtask

    task automatic checkRdReq(input string name, input rdReq_t exp, input rdReq_t act);
        if (act !== exp)
        begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            failRun();
        end
    endtask

    task automatic checkEntry(input string name, input dscrptrEntry_t exp,
                              input dscrptrEntry_t act);
        if (act !== exp)
        begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            failRun();
        end
    endtask

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    task automatic buildTable();
        stimTable.push_back(stimRow_t'{"fetch dv11", 1'b0, 32'h1000_0000, 2'd0,
                                       32'h0000_0abc, 2'b11, 1'b1, 1'b1});
        stimTable.push_back(stimRow_t'{"fetch dv10", 1'b0, 32'h1000_0010, 2'd1,
                                       32'h0000_2fff, 2'b10, 1'b1, 1'b0});
        stimTable.push_back(stimRow_t'{"check dv11", 1'b1, 32'h1000_0000, 2'd0,
                                       32'h0000_0000, 2'b11, 1'b1, 1'b1});
        stimTable.push_back(stimRow_t'{"check dv01", 1'b1, 32'h2000_0040, 2'd3,
                                       32'h0000_2000, 2'b01, 1'b1, 1'b0});
        stimTable.push_back(stimRow_t'{"fetch dv01", 1'b0, 32'h2000_0040, 2'd2,
                                       32'h0001_1234, 2'b01, 1'b0, 1'b0});
        stimTable.push_back(stimRow_t'{"fetch ones", 1'b0, 32'h3000_0080, 2'd3,
                                       32'hffff_dfff, 2'b11, 1'b1, 1'b1});
        stimTable.push_back(stimRow_t'{"check dv00", 1'b1, 32'h3000_0fff, 2'd1,
                                       32'hffff_ffff, 2'b00, 1'b0, 1'b0});
        stimTable.push_back(stimRow_t'{"fetch dv00", 1'b0, 32'hffff_fff0, 2'd1,
                                       32'h0000_0000, 2'b00, 1'b1, 1'b0});
    endtask

    // Queue fill rows with every odd one missing a data-valid bit
    function automatic stimRow_t backPressureRow(input int k);
        logic odd;
        odd = k[0];
        return stimRow_t'{$sformatf("backpressure %0d", k), 1'b0,
                          32'h4000_0000 + k * 32'h40, `SLOT_WIDTH'(k), $urandom,
                          odd ? 2'b10 : 2'b11, 1'b1, !odd};
    endfunction

    //////////////////////////////
    // Command and memory side
    //////////////////////////////

    task automatic driveCmd(input stimRow_t row);
        @(posedge clock);
        #DRIVE_DLY;
        cmdValid    = 1'b1;
        cmd.isCheck = row.isCheck;
        cmd.addr    = row.addr;
        cmd.slot    = row.slot;
    endtask

    task automatic awaitAccept(input string name);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!cmdReady)
        begin
            cycles++;
            if (cycles > TIMEOUT)
            begin
                $display("Timeout: command %s was never accepted", name);
                failRun();
            end
            @(negedge clock);
        end
        @(posedge clock);
        #DRIVE_DLY;
        cmdValid = 1'b0;
        @(negedge clock);
        checkBit({name, " cmdReady busy"}, 1'b0, cmdReady);
        checkBit({name, " rdReqValid"}, 1'b1, rdReqValid);
    endtask

    // Memory model answers the pending read after a random delay
    task automatic serveRead(input stimRow_t row);
        rdReq_t         expReq;
        rdResp_t        resp;
        dscrptrEntry_t  expEntry;
        int             delay;
        expReq.isCheck = row.isCheck;
        expReq.addr    = row.isCheck ? row.addr + `CONFIG_BYTE_OFFSET : row.addr;
        checkRdReq({row.name, " read request"}, expReq, rdReq);
        resp.data.configWord = row.cfg;
        resp.data.srcAddr    = $urandom;
        resp.data.dstAddr    = $urandom;
        resp.data.nextAddr   = $urandom;
        resp.dataValid       = row.dataValid;
        resp.dscrptrValid    = row.dscrptrValid;
        if (!row.isCheck)
        begin
            expEntry.dscrptr                             = resp.data;
            expEntry.dscrptr.configWord.fields.dataValid = row.expDv;
            expEntry.addr                                = row.addr;
            expEntry.slot                                = row.slot;
            expEntry.dscrptrValid                        = row.dscrptrValid;
            expQ.push_back(expEntry);
            fetchCount++;
        end
        delay = $urandom_range(4);
        repeat (delay) @(posedge clock);
        @(posedge clock);
        #DRIVE_DLY;
        rdRespValid = 1'b1;
        rdResp      = resp;
        @(posedge clock);
        #DRIVE_DLY;
        rdRespValid = 1'b0;
        @(negedge clock);
        checkBit({row.name, " rdyValid"}, row.isCheck, rdyValid);
        if (row.isCheck)
            checkBit({row.name, " rdy"}, row.expDv, rdy);
        @(negedge clock);
        checkBit({row.name, " rdyValid end"}, 1'b0, rdyValid);
    endtask

    task automatic runRow(input stimRow_t row);
        driveCmd(row);
        awaitAccept(row.name);
        serveRead(row);
    endtask

    task automatic awaitDrain(input string name);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (ackCount != fetchCount || load)
        begin
            cycles++;
            if (cycles > TIMEOUT)
            begin
                $display("Timeout: loads after %s were not all acknowledged", name);
                failRun();
            end
            @(negedge clock);
        end
    endtask

    //////////////////////////////
    // Transfer controller model
    //////////////////////////////

    always
    begin : ackModel
        dscrptrEntry_t exp;
        int            delay;
        @(negedge clock);
        if (resetn && load && acksAllowed > 0)
        begin
            if (expQ.size() == 0)
            begin
                $display("Load raised with no fetch outstanding, slot %0d", loadEntry.slot);
                failRun();
            end
            exp = expQ.pop_front();
            checkEntry($sformatf("load %0d", ackCount), exp, loadEntry);
            acksAllowed--;
            delay = $urandom_range(3);
            repeat (delay) @(posedge clock);
            @(posedge clock);
            #DRIVE_DLY;
            loadAck = 1'b1;
            @(posedge clock);
            #DRIVE_DLY;
            loadAck = 1'b0;
            @(negedge clock);
            checkBit("load drop after ack", 1'b0, load);
            checkBit("fetchDone pulse", 1'b1, fetchDone);
            ackCount++;
            @(negedge clock);
            checkBit("fetchDone clear", 1'b0, fetchDone);
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin : mainSeq
        stimRow_t extra;
        resetn      = 1'b0;
        cmdValid    = 1'b0;
        cmd         = '0;
        rdRespValid = 1'b0;
        rdResp      = '0;
        loadAck     = 1'b0;
        acksAllowed = 0;
        fetchCount  = 0;
        ackCount    = 0;
        void'($urandom(32'hb78c2a05));
        buildTable();

        repeat (16) @(posedge clock);
        #DRIVE_DLY;
        resetn = 1'b1;
        @(negedge clock);
        checkBit("reset cmdReady", 1'b1, cmdReady);
        checkBit("reset rdReqValid", 1'b0, rdReqValid);
        checkBit("reset load", 1'b0, load);
        checkBit("reset fetchDone", 1'b0, fetchDone);
        checkBit("reset rdyValid", 1'b0, rdyValid);

        // Fetches and checks in order with delayed acknowledges
        acksAllowed = 1000;
        foreach (stimTable[i])
            runRow(stimTable[i]);
        awaitDrain("table");

        // Loader holds one and the queue fills up behind it
        acksAllowed = 0;
        for (int k = 0; k < `DSCRPTR_QUEUE_DEPTH + 1; k++)
            runRow(backPressureRow(k));
        extra = backPressureRow(`DSCRPTR_QUEUE_DEPTH + 1);
        driveCmd(extra);
        repeat (4)
        begin
            @(negedge clock);
            checkBit("backpressure cmdReady hold", 1'b0, cmdReady);
        end
        acksAllowed = 1;
        awaitAccept(extra.name);
        serveRead(extra);
        acksAllowed = 1000;
        awaitDrain("backpressure");

        repeat (3) @(negedge clock);
        checkBit("no stray load", 1'b0, load);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
dscrptrPkg.sv
fetchSequencer.sv
dscrptrQueue.sv
dscrptrLoader.sv
dscrptrFetchTop.sv
dscrptrFetchTb.sv

//--- Bender.yml
package:
  name: dscrptr_fetch

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dscrptrPkg.sv
      - fetchSequencer.sv
      - dscrptrQueue.sv
      - dscrptrLoader.sv
      - dscrptrFetchTop.sv

  - target: simulation
    include_dirs:
      - .
    files:
      - dscrptrFetchTb.sv
